/* hdl/pgm_ddram_cfg.svh */
`ifndef PGM_DDRAM_CFG_SVH
`define PGM_DDRAM_CFG_SVH

// DDRAM port geometry
`define PGM_DDRAM_AW 29           // Word address, one word is 8 bytes
`define PGM_DDRAM_DW 64
`define PGM_DDRAM_BEW 8           // One enable per byte of a word

// Client address widths
`define PGM_CPU_AW 24             // 68000 byte address
`define PGM_IOCTL_AW 27           // Loader byte address

// Width of one CPU or loader word
`define PGM_WORD_W 16

// Loader image index of the program and BIOS ROM
`define PGM_LOADER_INDEX 8'd0

`endif

/* hdl/pgm_ddram_pkg.sv */
`default_nettype none

package pgm_ddram_pkg;

    `include "pgm_ddram_cfg.svh"

    // Memory side of the DDRAM port
    typedef logic [`PGM_DDRAM_AW-1:0]  ddram_addr_t;
    typedef logic [`PGM_DDRAM_DW-1:0]  ddram_data_t;
    typedef logic [`PGM_DDRAM_BEW-1:0] ddram_be_t;

    // Word as the main CPU sees it
    typedef logic [`PGM_WORD_W-1:0] cpu_word_t;

endpackage

`default_nettype wire

/* hdl/pgm_arb_pkg.sv */
`default_nettype none

package pgm_arb_pkg;

    `include "pgm_ddram_cfg.svh"

    // Which read client owns the DDRAM port
    typedef enum logic [1:0] {
        arb_idle  = 2'd0,
        arb_cpu   = 2'd1,
        arb_video = 2'd2,
        arb_audio = 2'd3
    } arb_state_t;

    // 16-bit lane inside one DDRAM word
    typedef logic [$clog2(`PGM_DDRAM_DW/`PGM_WORD_W)-1:0] lane_t;

endpackage

`default_nettype wire

/* hdl/ddram_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pgm_ddram_cfg.svh"

module ddram_arbiter
    import pgm_ddram_pkg::*;
    import pgm_arb_pkg::*;
(
    input  wire                    fixed_50m_clk,
    input  wire                    reset,
    input  wire                    ioctl_download,

    // Main CPU program fetch
    input  wire                    cpu_req,
    input  wire [`PGM_CPU_AW-1:0]  cpu_addr,
    output logic                   cpu_ack,
    output cpu_word_t              cpu_data,

    // Video engine
    input  wire                    vid_rd,
    input  ddram_addr_t            vid_addr,
    output logic                   vid_ack,

    // Audio sample engine
    input  wire                    sound_rd,
    input  ddram_addr_t            sound_addr,
    output logic                   sound_ack,

    // Loader address, used while downloading
    input  ddram_addr_t            wr_addr,

    // DDRAM read side
    output logic                   ddram_rd,
    output ddram_addr_t            ddram_addr,
    input  ddram_data_t            ddram_dout,
    input  wire                    ddram_dout_ready
);

    arb_state_t  state;
    logic        sound_rd_last;    // sound_rd one cycle ago
    logic        sound_rise;
    logic        read_done;        // Memory answered the current grant
    ddram_data_t cpu_buf;
    lane_t       cpu_lane;

    assign sound_rise = sound_rd && !sound_rd_last;
    assign read_done  = ddram_dout_ready && !ioctl_download;

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            sound_rd_last <= 1'b0;
        end else begin
            sound_rd_last <= sound_rd;
        end
    end

    // Grant FSM
    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            state <= arb_idle;
        end else if (ioctl_download) begin
            state <= arb_idle;         // Loader owns the port
        end else begin
            case (state)
                arb_idle: begin
                    if (cpu_req) begin
                        state <= arb_cpu;
                    end else if (vid_rd) begin
                        state <= arb_video;
                    end else if (sound_rise) begin
                        state <= arb_audio;
                    end
                end
                arb_cpu, arb_video, arb_audio: begin
                    if (ddram_dout_ready) begin
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // One-cycle acks for CPU and video, the cycle after ready
    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            cpu_ack <= 1'b0;
            vid_ack <= 1'b0;
        end else begin
            cpu_ack <= (state == arb_cpu) && read_done;
            vid_ack <= (state == arb_video) && read_done;
        end
    end

    // Audio ack is held until the engine drops its request
    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            sound_ack <= 1'b0;
        end else if ((state == arb_audio) && read_done) begin
            sound_ack <= 1'b1;
        end else if (!sound_rd) begin
            sound_ack <= 1'b0;
        end
    end

    always_ff @(posedge fixed_50m_clk) begin
        if ((state == arb_cpu) && read_done) begin
            cpu_buf <= ddram_dout;
        end
    end

    // CPU sees the 16-bit lane picked by its byte address
    assign cpu_lane = lane_t'(cpu_addr[2:1]);
    assign cpu_data = cpu_buf[`PGM_WORD_W*cpu_lane +: `PGM_WORD_W];

    assign ddram_rd = !ioctl_download && (state != arb_idle);

    always_comb begin
        if (ioctl_download) begin
            ddram_addr = wr_addr;
        end else begin
            case (state)
                arb_cpu:   ddram_addr = ddram_addr_t'(cpu_addr[`PGM_CPU_AW-1:3]);
                arb_audio: ddram_addr = sound_addr;
                default:   ddram_addr = vid_addr;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/loader_write_latch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pgm_ddram_cfg.svh"

module loader_write_latch
    import pgm_ddram_pkg::*;
    import pgm_arb_pkg::*;
(
    input  wire                     fixed_50m_clk,
    input  wire                     reset,

    // Loader side
    input  wire                     ioctl_download,
    input  wire                     ioctl_wr,
    input  wire [`PGM_IOCTL_AW-1:0] ioctl_addr,
    input  wire [`PGM_WORD_W-1:0]   ioctl_dout,
    input  wire [7:0]               ioctl_index,
    output logic                    ioctl_wait,

    // DDRAM write side
    input  wire                     ddram_busy,
    output logic                    ddram_we,
    output ddram_data_t             ddram_din,
    output ddram_be_t               ddram_be,
    output ddram_addr_t             wr_addr
);

    logic        pending;
    logic        take;         // Accept a new loader write this cycle
    lane_t       wr_lane;
    ddram_addr_t addr_lat;
    ddram_data_t data_lat;
    ddram_be_t   be_lat;

    assign take = ioctl_download && ioctl_wr && !pending &&
                  (ioctl_index == `PGM_LOADER_INDEX);
    assign wr_lane = lane_t'(ioctl_addr[2:1]);

    always_ff @(posedge fixed_50m_clk) begin
        if (reset || !ioctl_download) begin
            pending <= 1'b0;
        end else if (take) begin
            pending <= 1'b1;
        end else if (pending && !ddram_busy) begin
            pending <= 1'b0;           // Memory took the write
        end
    end

    // Held steady while the memory is busy
    always_ff @(posedge fixed_50m_clk) begin
        if (take) begin
            addr_lat <= ddram_addr_t'(ioctl_addr[`PGM_IOCTL_AW-1:3]);
            data_lat <= {(`PGM_DDRAM_DW/`PGM_WORD_W){ioctl_dout}};
            be_lat   <= ddram_be_t'(2'b11) << {wr_lane, 1'b0};  // Byte pair of the lane
        end
    end

    assign ddram_we   = pending;
    assign ioctl_wait = pending;
    assign ddram_din  = data_lat;
    assign ddram_be   = pending ? be_lat : '1;
    assign wr_addr    = addr_lat;

endmodule

`default_nettype wire

/* hdl/pgm_ddram_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pgm_ddram_cfg.svh"

module pgm_ddram_top
    import pgm_ddram_pkg::*;
(
    input  wire                     fixed_50m_clk,
    input  wire                     reset,

    // Main CPU
    input  wire                     cpu_req,
    input  wire [`PGM_CPU_AW-1:0]   cpu_addr,
    output logic                    cpu_ack,
    output cpu_word_t               cpu_data,

    // Video engine, data taken from ddram_dout
    input  wire                     vid_rd,
    input  ddram_addr_t             vid_addr,
    output logic                    vid_ack,

    // Audio engine, data taken from ddram_dout
    input  wire                     sound_rd,
    input  ddram_addr_t             sound_addr,
    output logic                    sound_ack,

    // ROM loader
    input  wire                     ioctl_download,
    input  wire                     ioctl_wr,
    input  wire [`PGM_IOCTL_AW-1:0] ioctl_addr,
    input  wire [`PGM_WORD_W-1:0]   ioctl_dout,
    input  wire [7:0]               ioctl_index,
    output logic                    ioctl_wait,

    // DDRAM port
    output logic                    ddram_rd,
    output logic                    ddram_we,
    output ddram_addr_t             ddram_addr,
    output ddram_data_t             ddram_din,
    output ddram_be_t               ddram_be,
    input  ddram_data_t             ddram_dout,
    input  wire                     ddram_busy,
    input  wire                     ddram_dout_ready
);

    ddram_addr_t wr_addr;      // Latched loader address

    ddram_arbiter u_arbiter (
        .fixed_50m_clk    (fixed_50m_clk),
        .reset            (reset),
        .ioctl_download   (ioctl_download),
        .cpu_req          (cpu_req),
        .cpu_addr         (cpu_addr),
        .cpu_ack          (cpu_ack),
        .cpu_data         (cpu_data),
        .vid_rd           (vid_rd),
        .vid_addr         (vid_addr),
        .vid_ack          (vid_ack),
        .sound_rd         (sound_rd),
        .sound_addr       (sound_addr),
        .sound_ack        (sound_ack),
        .wr_addr          (wr_addr),
        .ddram_rd         (ddram_rd),
        .ddram_addr       (ddram_addr),
        .ddram_dout       (ddram_dout),
        .ddram_dout_ready (ddram_dout_ready)
    );

    loader_write_latch u_loader (
        .fixed_50m_clk  (fixed_50m_clk),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .ioctl_index    (ioctl_index),
        .ioctl_wait     (ioctl_wait),
        .ddram_busy     (ddram_busy),
        .ddram_we       (ddram_we),
        .ddram_din      (ddram_din),
        .ddram_be       (ddram_be),
        .wr_addr        (wr_addr)
    );

endmodule

`default_nettype wire

/* test/pgm_ddram_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pgm_ddram_cfg.svh"

module pgm_ddram_asserts
    import pgm_ddram_pkg::*;
    import pgm_arb_pkg::*;
(
    input wire                     fixed_50m_clk,
    input wire                     reset,
    input wire                     cpu_req, vid_rd, sound_rd, cpu_ack, vid_ack, sound_ack,
    input wire [`PGM_CPU_AW-1:0]   cpu_addr,
    input ddram_addr_t             vid_addr, sound_addr, ddram_addr,
    input wire                     ioctl_download, ioctl_wr, ioctl_wait,
    input wire                     ddram_rd, ddram_we, ddram_busy, ddram_dout_ready,
    input wire [`PGM_IOCTL_AW-1:0] ioctl_addr,
    input wire [`PGM_WORD_W-1:0]   ioctl_dout,
    input wire [7:0]               ioctl_index,
    input ddram_data_t             ddram_din,
    input ddram_be_t               ddram_be,
    input arb_state_t              arb_state
);

    int   fail_count = 0;
    logic started;                 // Some client or the loader has been active

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            started <= 1'b0;
        end else if (cpu_req || vid_rd || sound_rd || ioctl_download) begin
            started <= 1'b1;
        end
    end

    task automatic flag_failure(input string msg);
        $error("%s", msg);
        fail_count++;
    endtask

    a_quiet: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        !started |-> !(ddram_rd || ddram_we || ioctl_wait || cpu_ack || vid_ack || sound_ack))
        else flag_failure("Outputs active before the first request");

    // Loader write path
    a_write_take: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ioctl_download && ioctl_wr && !ddram_we && ioctl_index == `PGM_LOADER_INDEX |=>
        ddram_we && ioctl_wait && ddram_din == {4{$past(ioctl_dout)}} &&
        ddram_addr == ddram_addr_t'($past(ioctl_addr[`PGM_IOCTL_AW-1:3])) &&
        ddram_be == (8'h03 << (2 * $past(ioctl_addr[2:1]))))
        else flag_failure("Loader write not presented with its address, data and enables");
    a_write_hold: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ddram_we && ddram_busy && ioctl_download |=> ddram_we && ioctl_wait &&
        $stable(ddram_addr) && $stable(ddram_din) && $stable(ddram_be))
        else flag_failure("Loader write changed while the memory was busy");
    a_write_release: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ddram_we && !ddram_busy |=> !ddram_we && !ioctl_wait)
        else flag_failure("Loader write still pending after the memory took it");
    a_other_index: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ioctl_wr && ioctl_index != `PGM_LOADER_INDEX && !ddram_we |=> !ddram_we)
        else flag_failure("Write with another index reached the memory");
    // No grant survives the download, even with requests waiting
    a_no_read_in_download: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ioctl_download |-> !ddram_rd ##1 !ddram_rd)
        else flag_failure("Read strobe high during or right after download");

    // Read arbitration
    a_read_addr: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ddram_rd && ddram_dout_ready |=>
        (!cpu_ack || $past(ddram_addr) == ddram_addr_t'($past(cpu_addr[`PGM_CPU_AW-1:3]))) &&
        (!vid_ack || $past(ddram_addr) == $past(vid_addr)) &&
        (!$rose(sound_ack) || $past(ddram_addr) == $past(sound_addr)))
        else flag_failure("Read address does not match the served client");
    a_read_ack: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        ddram_dout_ready && !ioctl_download && arb_state != arb_idle |=>
        cpu_ack == ($past(arb_state) == arb_cpu) && vid_ack == ($past(arb_state) == arb_video) &&
        (sound_ack || $past(arb_state) != arb_audio) && arb_state == arb_idle)
        else flag_failure("Wrong ack after the memory answered");
    a_ack_pulse: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        cpu_ack || vid_ack |=> !cpu_ack && !vid_ack)
        else flag_failure("CPU or video ack longer than one cycle");
    a_cpu_first: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        arb_state == arb_idle && cpu_req && vid_rd && !ioctl_download |=>
        arb_state == arb_cpu && ddram_addr == ddram_addr_t'($past(cpu_addr[`PGM_CPU_AW-1:3])))
        else flag_failure("Video read granted ahead of the CPU");

    // Audio ack is held by sound_rd
    a_sound_hold: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        sound_ack |=> sound_ack == $past(sound_rd))
        else flag_failure("Audio ack did not follow sound_rd");
    a_sound_once: assert property (@(posedge fixed_50m_clk) disable iff (reset)
        sound_ack |-> arb_state != arb_audio)
        else flag_failure("Second audio read while the ack was held");

endmodule

`default_nettype wire

/* test/tb_pgm_ddram_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pgm_ddram_cfg.svh"

module tb_pgm_ddram_top
    import pgm_ddram_pkg::*;
();

    localparam int txn_count  = 60;
    localparam int txn_cycles = 10;
    localparam int clk_period = 20;

    logic                     fixed_50m_clk = 1'b0;
    logic                     reset;
    logic                     cpu_req, vid_rd, sound_rd, cpu_ack, vid_ack, sound_ack;
    logic [`PGM_CPU_AW-1:0]   cpu_addr;
    cpu_word_t                cpu_data;
    ddram_addr_t              vid_addr, sound_addr, ddram_addr;
    logic                     ioctl_download, ioctl_wr, ioctl_wait;
    logic [`PGM_IOCTL_AW-1:0] ioctl_addr;
    logic [`PGM_WORD_W-1:0]   ioctl_dout;
    logic [7:0]               ioctl_index;
    logic                     ddram_rd, ddram_we, ddram_busy, ddram_dout_ready;
    ddram_data_t              ddram_din, ddram_dout;
    ddram_be_t                ddram_be;
    int                       rd_delay;
    int                       data_errors;
    int                       assert_errors;

    always #(clk_period / 2) fixed_50m_clk = ~fixed_50m_clk;

    pgm_ddram_top u_pgm_ddram_top (.*);

    bind pgm_ddram_top pgm_ddram_asserts u_asserts (.*, .arb_state(u_arbiter.state));

    // Memory contents, every bit set by the word address
    function automatic ddram_data_t model_word(input ddram_addr_t addr);
        return {3'b101, addr, 3'b011, ~addr};
    endfunction

    // DDRAM model with a random read latency
    always @(negedge fixed_50m_clk) begin
        ddram_busy = ddram_we && ($urandom_range(0, 1) != 0);  // Back-pressure on writes
        if (ddram_dout_ready) begin
            ddram_dout_ready = 1'b0;
        end else if (ddram_rd) begin
            if (rd_delay == 0) begin
                rd_delay = $urandom_range(1, 4);
            end
            rd_delay--;
            if (rd_delay == 0) begin
                ddram_dout = model_word(ddram_addr);
                ddram_dout_ready = 1'b1;
            end
        end
    end

    task automatic check_cpu_data(input logic [`PGM_CPU_AW-1:0] addr);
        ddram_data_t word;
        cpu_word_t   expect_word;
        word = model_word(ddram_addr_t'(addr[`PGM_CPU_AW-1:3]));
        expect_word = word[`PGM_WORD_W * addr[2:1] +: `PGM_WORD_W];  // Lane from bits 2..1
        if (cpu_data !== expect_word) begin
            data_errors++;
            $display("ERR %0t: cpu_data %h, expected %h at address %h",
                     $time, cpu_data, expect_word, addr);
        end
    endtask

    task automatic loader_write(input logic [7:0] index);
        ioctl_wr = 1'b1;
        ioctl_index = index;
        ioctl_addr = `PGM_IOCTL_AW'($urandom);
        ioctl_dout = `PGM_WORD_W'($urandom);
        @(negedge fixed_50m_clk);
        ioctl_wr = 1'b0;
        while (ioctl_wait) @(negedge fixed_50m_clk);
    endtask

    // Requests are dropped in the ack cycle so no second grant follows
    task automatic client_read(input logic use_cpu, input logic use_vid);
        cpu_req = use_cpu;
        vid_rd = use_vid;
        cpu_addr = `PGM_CPU_AW'($urandom);
        vid_addr = ddram_addr_t'($urandom);
        @(negedge fixed_50m_clk);
        while (cpu_req && !cpu_ack) @(negedge fixed_50m_clk);
        if (use_cpu) begin
            cpu_req = 1'b0;
            check_cpu_data(cpu_addr);
        end
        while (vid_rd && !vid_ack) @(negedge fixed_50m_clk);
        vid_rd = 1'b0;
    endtask

    task automatic audio_read();
        sound_rd = 1'b1;
        sound_addr = ddram_addr_t'($urandom);
        @(negedge fixed_50m_clk);
        while (!sound_ack) @(negedge fixed_50m_clk);
        repeat ($urandom_range(2, 4)) @(negedge fixed_50m_clk);  // Ack must stay up
        sound_rd = 1'b0;
        repeat (2) @(negedge fixed_50m_clk);
    endtask

    initial begin
        void'($urandom(34043));
        {reset, cpu_req, vid_rd, sound_rd} = 4'b1000;
        {ioctl_download, ioctl_wr, ioctl_addr, ioctl_dout, ioctl_index} = '0;
        {cpu_addr, vid_addr, sound_addr, ddram_dout} = '0;
        {ddram_busy, ddram_dout_ready} = 2'b00;
        rd_delay = 0;
        data_errors = 0;
        repeat (3) @(negedge fixed_50m_clk);
        reset = 1'b0;
        repeat (3) @(negedge fixed_50m_clk);      // Quiet before any request
        ioctl_download = 1'b1;
        cpu_req = 1'b1;                           // Held off while the loader owns the port
        vid_rd = 1'b1;
        for (int i = 0; i < 12; i++) begin
            loader_write((i % 6 == 5) ? 8'd1 : `PGM_LOADER_INDEX);
        end
        ioctl_download = 1'b0;
        cpu_req = 1'b0;
        vid_rd = 1'b0;
        @(negedge fixed_50m_clk);
        for (int i = 0; i < 16; i++) client_read(1'b1, 1'b0);
        for (int i = 0; i < 8; i++) client_read(1'b0, 1'b1);
        for (int i = 0; i < 6; i++) client_read(1'b1, 1'b1);    // CPU ahead of video
        for (int i = 0; i < 6; i++) audio_read();
        repeat (2) @(negedge fixed_50m_clk);
        assert_errors = u_pgm_ddram_top.u_asserts.fail_count;
        $display("Errors: %0d cpu_data mismatches, %0d assertion failures",
                 data_errors, assert_errors);
        if (data_errors == 0 && assert_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(txn_count * txn_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d ns",
                 txn_count * txn_cycles * clk_period);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* pgm_ddram_top.f */
+incdir+hdl
hdl/pgm_ddram_pkg.sv
hdl/pgm_arb_pkg.sv
hdl/ddram_arbiter.sv
hdl/loader_write_latch.sv
hdl/pgm_ddram_top.sv
test/pgm_ddram_asserts.sv
test/tb_pgm_ddram_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DDRAM testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns -f pgm_ddram_top.f \
    --top-module tb_pgm_ddram_top -o sim_pgm_ddram
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_pgm_ddram +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
